/* sim.f */
+incdir+include
src/pic_pkg.sv
src/pic_cmd_decoder.sv
src/pic_priority_resolver.sv
src/pic_controller.sv
src/pic_top.sv
verification/pic_asserts.sv
verification/pic_tb.sv

/* Makefile */
TOP = pic_tb

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"

test:
	verilator --binary --timing --assert -f sim.f --top-module $(TOP) -o $(TOP)
	@out=$$(./obj_dir/$(TOP)); echo "$$out"; echo "$$out" | grep -q "ALL TESTS PASSED"

clean:
	rm -rf obj_dir

/* verification/pic_tb.sv */
// pic pair testbench

`timescale 1ns/1ps

`include "pic_cfg.svh"

module pic_tb;
    import pic_pkg::*;

    localparam int MAX_CYCLES  = 4000;
    localparam int WAIT_CYCLES = 20;   // bounded wait for interrupt_do
    localparam int_vector_t MASTER_BASE = 8'h08;
    localparam int_vector_t SLAVE_BASE  = 8'h70;

    logic        clk;
    logic        rst_n;
    logic        io_address;
    logic        io_read;
    logic        io_write;
    io_data_t    io_writedata;
    io_data_t    io_readdata;
    logic        io_master_cs;
    logic        io_slave_cs;
    logic [15:0] interrupt_input;
    logic        interrupt_do;
    int_vector_t interrupt_vector;
    logic        interrupt_done;

    int          error_count;
    int          check_count;
    int          cycle_count;
    int unsigned lcg_state;

    pic_top dut_i (
        .clk             (clk),
        .rst_n           (rst_n),
        .io_address      (io_address),
        .io_read         (io_read),
        .io_write        (io_write),
        .io_writedata    (io_writedata),
        .io_readdata     (io_readdata),
        .io_master_cs    (io_master_cs),
        .io_slave_cs     (io_slave_cs),
        .interrupt_input (interrupt_input),
        .interrupt_do    (interrupt_do),
        .interrupt_vector(interrupt_vector),
        .interrupt_done  (interrupt_done)
    );

    always #5 clk = ~clk;

    // run limit
    always @(posedge clk) begin
        cycle_count = cycle_count + 1;
        if (cycle_count >= MAX_CYCLES) begin
            $display("run stopped after %0d cycles without finishing", cycle_count);
            $display("SOME TESTS FAILED");
            $finish;
        end
    end

    // ----------------------------------------
    // helpers
    // ----------------------------------------

    function automatic int unsigned lcg_next();
        lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
        return lcg_state >> 16;
    endfunction

    // any master line but the cascade input
    function automatic int pick_master_line();
        int line;
        line = 2;
        while (line == 2) begin
            line = int'(lcg_next() % 8);
        end
        return line;
    endfunction

    task automatic tick();
        @(posedge clk);
        #1;
    endtask

    task automatic io_write_byte(input logic master, input logic addr, input io_data_t data);
        io_master_cs = master;
        io_slave_cs  = !master;
        io_address   = addr;
        io_writedata = data;
        io_write     = 1'b1;
        tick();
        io_write     = 1'b0;
        io_master_cs = 1'b0;
        io_slave_cs  = 1'b0;
    endtask

    task automatic io_read_byte(input logic master, input logic addr, output io_data_t data);
        io_master_cs = master;
        io_slave_cs  = !master;
        io_address   = addr;
        io_read      = 1'b1;
        tick();
        io_read      = 1'b0;
        io_master_cs = 1'b0;
        io_slave_cs  = 1'b0;
        data = io_readdata;  // registered at the edge just passed
    endtask

    task automatic check_data(input string name, input io_data_t actual,
                              input io_data_t expected);
        check_count++;
        if (actual !== expected) begin
            error_count++;
            $display("FAILED %s: got %02h, expected %02h", name, actual, expected);
        end
    endtask

    task automatic check_vector(input string name, input int_vector_t actual,
                                input int_vector_t expected);
        check_count++;
        if (actual !== expected) begin
            error_count++;
            $display("FAILED %s: got %02h, expected %02h", name, actual, expected);
        end
    endtask

    task automatic report_error(input string msg);
        error_count++;
        $display("error: %s", msg);
    endtask

    task automatic set_line(input logic [3:0] idx, input logic value);
        interrupt_input[idx] = value;
    endtask

    // OCW3 picks IRR or ISR, then read address 0
    task automatic read_status(input logic master, input logic isr, input io_data_t expected,
                               input string name);
        io_data_t data;
        io_write_byte(master, 1'b0, isr ? 8'h0B : 8'h0A);
        io_read_byte(master, 1'b0, data);
        check_data(name, data, expected);
    endtask

    task automatic wait_irq(input int limit, output logic seen);
        seen = interrupt_do;
        for (int i = 0; i < limit && !seen; i++) begin
            tick();
            seen = interrupt_do;
        end
    endtask

    task automatic expect_irq(input int_vector_t expected, input string what);
        logic seen;
        wait_irq(WAIT_CYCLES, seen);
        if (!seen) begin
            report_error($sformatf("interrupt_do never rose for %s", what));
        end else begin
            check_vector("interrupt_vector", interrupt_vector, expected);
        end
    endtask

    task automatic acknowledge();
        interrupt_done = 1'b1;
        tick();
        interrupt_done = 1'b0;
        if (interrupt_do) begin
            report_error("interrupt_do still high after interrupt_done");
        end
    endtask

    // ----------------------------------------
    // directed tests
    // ----------------------------------------

    task automatic init_and_readback();
        io_data_t data;
        io_write_byte(1'b1, 1'b0, 8'h11);  // master ICW1, ICW4 follows
        io_write_byte(1'b1, 1'b1, 8'h08);
        io_write_byte(1'b1, 1'b1, 8'h04);
        io_write_byte(1'b1, 1'b1, 8'h01);
        io_write_byte(1'b0, 1'b0, 8'h10);  // slave ICW1, no ICW4
        io_write_byte(1'b0, 1'b1, 8'h70);
        io_write_byte(1'b0, 1'b1, 8'h02);
        io_read_byte(1'b1, 1'b1, data);
        check_data("master IMR", data, 8'h00);
        io_write_byte(1'b1, 1'b1, 8'hA5);
        io_write_byte(1'b0, 1'b1, 8'h5A);
        io_read_byte(1'b1, 1'b1, data);
        check_data("master IMR", data, 8'hA5);
        io_read_byte(1'b0, 1'b1, data);
        check_data("slave IMR", data, 8'h5A);
        io_write_byte(1'b1, 1'b1, 8'h00);
        io_write_byte(1'b0, 1'b1, 8'h00);
        read_status(1'b1, 1'b0, 8'h00, "master IRR");
        read_status(1'b1, 1'b1, 8'h00, "master ISR");
        read_status(1'b0, 1'b0, 8'h00, "slave IRR");
        read_status(1'b0, 1'b1, 8'h00, "slave ISR");
    endtask

    task automatic single_master_irq();
        set_line(4'd5, 1'b1);
        expect_irq(MASTER_BASE | 8'h05, "line 5");
        acknowledge();
        read_status(1'b1, 1'b1, 8'h20, "master ISR");
        set_line(4'd5, 1'b0);
        io_write_byte(1'b1, 1'b0, `PIC_OCW2_EOI);
        read_status(1'b1, 1'b1, 8'h00, "master ISR");
    endtask

    task automatic priority_and_mask();
        int   a;
        int   b;
        int   lo;
        int   hi;
        int   masked;
        logic seen;
        a = pick_master_line();
        b = a;
        while (b == a) begin
            b = pick_master_line();
        end
        lo = (a < b) ? a : b;
        hi = (a < b) ? b : a;
        set_line(4'(a), 1'b1);
        set_line(4'(b), 1'b1);
        expect_irq(MASTER_BASE | 8'(lo), "lower of two lines");
        acknowledge();
        set_line(4'(lo), 1'b0);
        io_write_byte(1'b1, 1'b0, `PIC_OCW2_EOI);
        expect_irq(MASTER_BASE | 8'(hi), "higher of two lines");
        acknowledge();
        set_line(4'(hi), 1'b0);
        io_write_byte(1'b1, 1'b0, `PIC_OCW2_EOI);
        read_status(1'b1, 1'b1, 8'h00, "master ISR");

        masked = pick_master_line();
        io_write_byte(1'b1, 1'b1, 8'(1 << masked));
        set_line(4'(masked), 1'b1);
        wait_irq(WAIT_CYCLES, seen);
        if (seen) begin
            report_error($sformatf("masked line %0d raised interrupt_do", masked));
        end
        set_line(4'(masked), 1'b0);
        tick();  // let the IRR bit drop before unmasking
        io_write_byte(1'b1, 1'b1, 8'h00);
    endtask

    task automatic cascade_irq();
        set_line(4'd12, 1'b1);
        expect_irq(SLAVE_BASE | 8'h04, "slave line 12");
        acknowledge();
        read_status(1'b1, 1'b1, 8'h04, "master ISR");
        read_status(1'b0, 1'b1, 8'h10, "slave ISR");
        set_line(4'd12, 1'b0);
        io_write_byte(1'b0, 1'b0, `PIC_OCW2_EOI);
        io_write_byte(1'b1, 1'b0, `PIC_OCW2_EOI);
        read_status(1'b1, 1'b1, 8'h00, "master ISR");
        read_status(1'b0, 1'b1, 8'h00, "slave ISR");
    endtask

    task automatic rotation_specific_eoi();
        io_write_byte(1'b1, 1'b0, (`PIC_OCW2_SET_PRIO | 8'h04));  // order 5,6,7,0..4
        set_line(4'd3, 1'b1);
        set_line(4'd6, 1'b1);
        expect_irq(MASTER_BASE | 8'h06, "line 6 after rotation");
        acknowledge();
        set_line(4'd6, 1'b0);
        read_status(1'b1, 1'b0, 8'h08, "master IRR");
        read_status(1'b1, 1'b1, 8'h40, "master ISR");
        io_write_byte(1'b1, 1'b0, (`PIC_OCW2_SPEC_EOI | 8'h03));  // line 3 not in service
        read_status(1'b1, 1'b1, 8'h40, "master ISR");
        io_write_byte(1'b1, 1'b0, (`PIC_OCW2_SPEC_EOI | 8'h06));
        read_status(1'b1, 1'b1, 8'h00, "master ISR");
        expect_irq(MASTER_BASE | 8'h03, "line 3 after specific EOI");
        acknowledge();
        set_line(4'd3, 1'b0);
        read_status(1'b1, 1'b1, 8'h08, "master ISR");
        io_write_byte(1'b1, 1'b0, (`PIC_OCW2_SPEC_EOI | 8'h03));
        read_status(1'b1, 1'b1, 8'h00, "master ISR");
        io_write_byte(1'b1, 1'b0, (`PIC_OCW2_SET_PRIO | 8'h07));
    endtask

    // offsets that differ from the reset values
    task automatic changed_offsets();
        io_write_byte(1'b1, 1'b0, 8'h10);  // master ICW1, no ICW4
        io_write_byte(1'b1, 1'b1, 8'h20);
        io_write_byte(1'b1, 1'b1, 8'h04);
        io_write_byte(1'b0, 1'b0, 8'h10);
        io_write_byte(1'b0, 1'b1, 8'h48);
        io_write_byte(1'b0, 1'b1, 8'h02);
        set_line(4'd1, 1'b1);
        expect_irq(8'h20 | 8'h01, "line 1 with master offset 20h");
        acknowledge();
        set_line(4'd1, 1'b0);
        io_write_byte(1'b1, 1'b0, `PIC_OCW2_EOI);
        set_line(4'd13, 1'b1);
        expect_irq(8'h48 | 8'h05, "slave line 13 with slave offset 48h");
        acknowledge();
        set_line(4'd13, 1'b0);
        io_write_byte(1'b0, 1'b0, `PIC_OCW2_EOI);
        io_write_byte(1'b1, 1'b0, `PIC_OCW2_EOI);
        read_status(1'b1, 1'b1, 8'h00, "master ISR");
        read_status(1'b0, 1'b1, 8'h00, "slave ISR");
    endtask

    // ----------------------------------------
    // main sequence
    // ----------------------------------------

    initial begin
        clk             = 1'b0;
        rst_n           = 1'b0;
        io_address      = 1'b0;
        io_read         = 1'b0;
        io_write        = 1'b0;
        io_writedata    = '0;
        io_master_cs    = 1'b0;
        io_slave_cs     = 1'b0;
        interrupt_input = '0;
        interrupt_done  = 1'b0;
        error_count     = 0;
        check_count     = 0;
        cycle_count     = 0;
        lcg_state       = 25637;
        repeat (3) @(posedge clk);
        #1;
        rst_n = 1'b1;
        tick();
        init_and_readback();
        single_master_irq();
        priority_and_mask();
        cascade_irq();
        rotation_specific_eoi();
        changed_offsets();
        $display("checks: %0d, errors: %0d", check_count, error_count);
        if (error_count == 0) begin
            $display("ALL TESTS PASSED");
        end else begin
            $display("SOME TESTS FAILED");
        end
        $finish;
    end

endmodule

/* verification/pic_asserts.sv */
// pic handshake assertions

`timescale 1ns/1ps

module pic_asserts (
    input logic                 clk,
    input logic                 rst_n,
    input logic                 interrupt_do,
    input pic_pkg::int_vector_t interrupt_vector,
    input logic                 interrupt_done
);
    logic [1:0] settle;

    // cycles since reset, saturates at 3
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            settle <= '0;
        end else if (settle != 2'd3) begin
            settle <= settle + 2'd1;
        end
    end

    quiet_after_reset: assert property (@(posedge clk) disable iff (!rst_n)
        (settle != 2'd3) |-> !interrupt_do)
        else $error("interrupt_do high in the first cycles after reset");

    // vector loads only on the rising edge of interrupt_do
    vector_stable: assert property (@(posedge clk) disable iff (!rst_n)
        $past(interrupt_do) |-> $stable(interrupt_vector))
        else $error("interrupt_vector changed while interrupt_do was high");

    done_drops_do: assert property (@(posedge clk) disable iff (!rst_n)
        interrupt_done |=> !interrupt_do)
        else $error("interrupt_do did not fall after interrupt_done");

endmodule

bind pic_top pic_asserts asserts_i (
    .clk             (clk),
    .rst_n           (rst_n),
    .interrupt_do    (interrupt_do),
    .interrupt_vector(interrupt_vector),
    .interrupt_done  (interrupt_done)
);

/* src/pic_top.sv */
// cascaded 8259 pair

`timescale 1ns/1ps

`include "pic_cfg.svh"

module pic_top (
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic                 io_address,
    input  logic                 io_read,
    input  logic                 io_write,
    input  pic_pkg::io_data_t    io_writedata,
    output pic_pkg::io_data_t    io_readdata,
    input  logic                 io_master_cs,
    input  logic                 io_slave_cs,
    input  logic [15:0]          interrupt_input,
    output logic                 interrupt_do,
    output pic_pkg::int_vector_t interrupt_vector,
    input  logic                 interrupt_done
);
    import pic_pkg::*;

    localparam irq_idx_t CASCADE = irq_idx_t'(`PIC_CASCADE_LINE);

    logic        master_write;
    logic        slave_write;
    logic        master_read;
    logic        slave_read;
    irq_vec_t    master_lines;
    logic        master_irq;
    int_vector_t master_vector;
    io_data_t    master_data;
    logic        slave_irq_latched;
    int_vector_t slave_vector;
    io_data_t    slave_data;
    logic        slave_active;
    logic        load_vector;
    irq_idx_t    master_ack_line;

    // ----------------------------------------
    // bus qualification
    // ----------------------------------------

    assign master_write = io_write && io_master_cs;
    assign slave_write  = io_write && io_slave_cs;
    assign master_read  = io_read && io_master_cs;
    assign slave_read   = io_read && io_slave_cs;

    // slave request replaces the cascade input
    always_comb begin
        master_lines = interrupt_input[7:0];
        master_lines[CASCADE] = slave_irq_latched;
    end

    assign master_ack_line = slave_active ? CASCADE : interrupt_vector[2:0];

    pic_controller #(
        .OFFSET_RST(`PIC_MASTER_OFFSET_RST)
    ) master_i (
        .clk        (clk),
        .rst_n      (rst_n),
        .write      (master_write),
        .address    (io_address),
        .writedata  (io_writedata),
        .lines      (master_lines),
        .ack        (interrupt_done),
        .ack_line   (master_ack_line),
        .irq        (master_irq),
        .irq_latched(interrupt_do),  // CPU request follows the master latch
        .vector     (master_vector),
        .read_data  (master_data)
    );

    pic_controller #(
        .OFFSET_RST(`PIC_SLAVE_OFFSET_RST)
    ) slave_i (
        .clk        (clk),
        .rst_n      (rst_n),
        .write      (slave_write),
        .address    (io_address),
        .writedata  (io_writedata),
        .lines      (interrupt_input[15:8]),
        .ack        (interrupt_done && slave_active),
        .ack_line   (interrupt_vector[2:0]),
        .irq        (),
        .irq_latched(slave_irq_latched),
        .vector     (slave_vector),
        .read_data  (slave_data)
    );

    // ----------------------------------------
    // vector handoff
    // ----------------------------------------

    assign load_vector = master_irq && !interrupt_do;  // same edge interrupt_do rises

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            interrupt_vector <= '0;
            slave_active     <= 1'b0;
        end else if (load_vector) begin
            slave_active     <= master_vector[2:0] == CASCADE;
            interrupt_vector <= (master_vector[2:0] == CASCADE) ? slave_vector : master_vector;
        end
    end

    // read data lands on the edge after the strobe
    always_ff @(posedge clk) begin
        if (master_read) begin
            io_readdata <= master_data;
        end else if (slave_read) begin
            io_readdata <= slave_data;
        end
    end

endmodule

/* src/pic_controller.sv */
// single 8259 chip

`timescale 1ns/1ps

`include "pic_cfg.svh"

module pic_controller #(
    parameter pic_pkg::vec_offset_t OFFSET_RST = `PIC_MASTER_OFFSET_RST
) (
    input  logic                clk,
    input  logic                rst_n,
    input  logic                write,
    input  logic                address,
    input  pic_pkg::io_data_t   writedata,
    input  pic_pkg::irq_vec_t   lines,
    input  logic                ack,
    input  pic_pkg::irq_idx_t   ack_line,
    output logic                irq,
    output logic                irq_latched,
    output pic_pkg::int_vector_t vector,
    output pic_pkg::io_data_t   read_data
);
    import pic_pkg::*;

    logic        init;
    logic        mask_write;
    logic        eoi_highest;
    logic        eoi_specific;
    irq_idx_t    eoi_line;
    logic        read_isr;
    irq_idx_t    lowest_priority;
    vec_offset_t offset;
    irq_idx_t    winner;
    irq_idx_t    top_in_service;

    irq_vec_t lines_q;
    irq_vec_t rise;
    irq_vec_t irr;
    irq_vec_t isr;
    irq_vec_t imr;
    irq_vec_t ack_bits;
    irq_vec_t isr_clear;

    pic_cmd_decoder #(
        .OFFSET_RST(OFFSET_RST)
    ) decoder_i (
        .clk            (clk),
        .rst_n          (rst_n),
        .write          (write),
        .address        (address),
        .writedata      (writedata),
        .init           (init),
        .mask_write     (mask_write),
        .eoi_highest    (eoi_highest),
        .eoi_specific   (eoi_specific),
        .eoi_line       (eoi_line),
        .read_isr       (read_isr),
        .lowest_priority(lowest_priority),
        .offset         (offset)
    );

    pic_priority_resolver resolver_i (
        .pending        (irr & ~imr),
        .in_service     (isr),
        .lowest_priority(lowest_priority),
        .irq            (irq),
        .winner         (winner),
        .top_in_service (top_in_service)
    );

    // ----------------------------------------
    // request capture
    // ----------------------------------------

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            lines_q <= '0;
        end else begin
            lines_q <= lines;
        end
    end

    assign rise = lines & ~lines_q;
    assign ack_bits = ack ? irq_vec_t'(1) << ack_line : '0;

    assign isr_clear = eoi_specific ? irq_vec_t'(1) << eoi_line :
                       eoi_highest  ? irq_vec_t'(1) << top_in_service : '0;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            irr <= '0;
            isr <= '0;
            imr <= '1;  // all lines masked until ICW1
        end else if (init) begin
            irr <= '0;
            isr <= '0;
            imr <= '0;
        end else begin
            irr <= (irr & lines & ~ack_bits) | rise;  // drops if line goes low
            isr <= (isr & ~isr_clear) | ack_bits;
            if (mask_write) begin
                imr <= writedata;
            end
        end
    end

    // held from request until the CPU takes it
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            irq_latched <= 1'b0;
        end else if (init || ack) begin
            irq_latched <= 1'b0;
        end else if (irq) begin
            irq_latched <= 1'b1;
        end
    end

    // ----------------------------------------
    // vector and read back
    // ----------------------------------------

    assign vector = {offset, winner};
    assign read_data = address  ? imr :
                       read_isr ? isr : irr;

endmodule

/* src/pic_priority_resolver.sv */
// pic rotating priority resolver

`timescale 1ns/1ps

`include "pic_cfg.svh"

module pic_priority_resolver (
    input  pic_pkg::irq_vec_t pending,
    input  pic_pkg::irq_vec_t in_service,
    input  pic_pkg::irq_idx_t lowest_priority,
    output logic              irq,
    output pic_pkg::irq_idx_t winner,
    output pic_pkg::irq_idx_t top_in_service
);
    import pic_pkg::*;

    irq_idx_t shift;
    irq_vec_t candidates;
    irq_vec_t rot_req;
    irq_vec_t rot_isr;
    irq_idx_t pos_req;
    irq_idx_t pos_isr;

    // ----------------------------------------
    // helpers
    // ----------------------------------------

    // move bit (shift + i) down to bit i
    function automatic irq_vec_t rotate(input irq_vec_t v, input irq_idx_t amount);
        logic [2*`PIC_LINES-1:0] doubled;
        doubled = {v, v} >> amount;
        return doubled[`PIC_LINES-1:0];
    endfunction

    // lowest set bit, last position when empty
    function automatic irq_idx_t first_set(input irq_vec_t v);
        irq_idx_t idx;
        idx = irq_idx_t'(`PIC_LINES - 1);
        for (int i = `PIC_LINES - 1; i >= 0; i--) begin
            if (v[i]) begin
                idx = irq_idx_t'(i);
            end
        end
        return idx;
    endfunction

    // ----------------------------------------
    // priority search
    // ----------------------------------------

    assign shift = lowest_priority + 3'd1;  // highest priority line
    assign candidates = pending & ~in_service;

    assign rot_req = rotate(candidates, shift);
    assign rot_isr = rotate(in_service, shift);

    assign pos_req = first_set(rot_req);
    assign pos_isr = first_set(rot_isr);

    // back to real line numbers
    assign winner = shift + pos_req;
    assign top_in_service = shift + pos_isr;

    // an empty ISR blocks nothing
    assign irq = (|candidates) && (in_service == '0 || pos_req < pos_isr);

endmodule

/* src/pic_cmd_decoder.sv */
// pic command decoder

`timescale 1ns/1ps

`include "pic_cfg.svh"

module pic_cmd_decoder #(
    parameter pic_pkg::vec_offset_t OFFSET_RST = `PIC_MASTER_OFFSET_RST
) (
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic                 write,
    input  logic                 address,
    input  pic_pkg::io_data_t    writedata,
    output logic                 init,
    output logic                 mask_write,
    output logic                 eoi_highest,
    output logic                 eoi_specific,
    output pic_pkg::irq_idx_t    eoi_line,
    output logic                 read_isr,
    output pic_pkg::irq_idx_t    lowest_priority,
    output pic_pkg::vec_offset_t offset
);
    import pic_pkg::*;

    logic       in_init;
    logic       need_icw4;
    logic [2:0] next_icw;
    logic       icw2;
    logic       icw3;
    logic       icw4;
    logic       ocw2;
    logic       ocw3;
    io_data_t   cmd_byte;

    // ----------------------------------------
    // write classification
    // ----------------------------------------

    assign init = write && !address && writedata[4];
    assign icw2 = write && address && in_init && next_icw == 3'd2;
    assign icw3 = write && address && in_init && next_icw == 3'd3;
    assign icw4 = write && address && in_init && next_icw == 3'd4;

    assign mask_write = write && address && !in_init;  // OCW1
    assign ocw2 = write && !address && writedata[4:3] == 2'b00;
    assign ocw3 = write && !address && writedata[4:3] == 2'b01;

    assign cmd_byte = {writedata[7:3], 3'b000};  // low bits carry the line

    assign eoi_highest = ocw2 && (cmd_byte == `PIC_OCW2_EOI || cmd_byte == `PIC_OCW2_ROT_EOI);
    assign eoi_specific = ocw2 &&
        (cmd_byte == `PIC_OCW2_SPEC_EOI || cmd_byte == `PIC_OCW2_ROT_SPEC_EOI);
    assign eoi_line = writedata[2:0];

    // ----------------------------------------
    // init sequence
    // ----------------------------------------

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            in_init   <= 1'b0;
            need_icw4 <= 1'b0;
            next_icw  <= 3'd0;
        end else if (init) begin
            in_init   <= 1'b1;
            need_icw4 <= writedata[0];  // IC4 bit
            next_icw  <= 3'd2;
        end else if (icw2) begin
            next_icw <= 3'd3;
        end else if (icw3) begin
            if (need_icw4) begin
                next_icw <= 3'd4;
            end else begin
                in_init <= 1'b0;  // sequence ends at ICW3
            end
        end else if (icw4) begin
            in_init <= 1'b0;  // contents ignored
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            offset <= OFFSET_RST;
        end else if (icw2) begin
            offset <= writedata[7:3];
        end
    end

    // ----------------------------------------
    // operation commands
    // ----------------------------------------

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            lowest_priority <= irq_idx_t'(`PIC_LINES - 1);
        end else if (init) begin
            lowest_priority <= irq_idx_t'(`PIC_LINES - 1);
        end else if (ocw2 && cmd_byte == `PIC_OCW2_ROT_EOI) begin
            lowest_priority <= lowest_priority + 3'd1;  // step round by one
        end else if (ocw2 && (cmd_byte == `PIC_OCW2_SET_PRIO ||
                              cmd_byte == `PIC_OCW2_ROT_SPEC_EOI)) begin
            lowest_priority <= writedata[2:0];  // named line goes last
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            read_isr <= 1'b0;
        end else if (init) begin
            read_isr <= 1'b0;
        end else if (ocw3 && writedata[1]) begin
            read_isr <= writedata[0];  // RR set, RIS picks ISR
        end
    end

endmodule

/* src/pic_pkg.sv */
// pic shared types

`include "pic_cfg.svh"

package pic_pkg;

    // ----------------------------------------
    // request line sets and indices
    // ----------------------------------------

    // one bit per request line
    typedef logic [`PIC_LINES-1:0] irq_vec_t;

    // index of one request line
    typedef logic [$clog2(`PIC_LINES)-1:0] irq_idx_t;

    // ----------------------------------------
    // vectors and bus data
    // ----------------------------------------

    // vector base from ICW2
    typedef logic [4:0] vec_offset_t;

    // offset in the upper bits, line index below
    typedef logic [7:0] int_vector_t;

    // byte on the I/O port
    typedef logic [7:0] io_data_t;

endpackage

/* include/pic_cfg.svh */
// pic configuration constants

`ifndef PIC_CFG_SVH
`define PIC_CFG_SVH

// ----------------------------------------
// chip geometry
// ----------------------------------------

// request lines per chip
`define PIC_LINES 8

// master line fed by the slave request latch
`define PIC_CASCADE_LINE 2

// ----------------------------------------
// vector offsets after reset
// ----------------------------------------

`define PIC_MASTER_OFFSET_RST 5'h01
`define PIC_SLAVE_OFFSET_RST 5'h0E

// ----------------------------------------
// OCW2 commands, upper five bits
// ----------------------------------------

`define PIC_OCW2_EOI 8'h20           // non-specific EOI
`define PIC_OCW2_ROT_EOI 8'hA0       // rotate on non-specific EOI
`define PIC_OCW2_SPEC_EOI 8'h60      // specific EOI, line in bits 2:0
`define PIC_OCW2_SET_PRIO 8'hC0      // set lowest priority line
`define PIC_OCW2_ROT_SPEC_EOI 8'hE0  // specific EOI plus rotate

`endif
